//--- bench/mem_checker.sv
`include "mem_defs.svh"

module mem_checker
    import mem_pkg::*;
(
    input  logic  lsdom_seq,
    input  logic  rst_i,
    input  logic  req_i,
    input  addr_t addr_i,
    input  logic  we_i,
    input  strb_t be_i,
    input  data_t wdata_i,
    input  logic  we_tag_i,
    input  logic  wdata_tag_i,
    input  logic  rvalid_i,
    input  data_t rdata_i,
    input  tag_t  rdata_tag_i,
    output int    err_count_o,
    output int    check_count_o,
    output int    pending_o
);

    // Model of the tagged RAM, data bytes are known only once written
    data_t ram_img   [`RAM_WORDS];
    strb_t ram_known [`RAM_WORDS];
    tag_t  tag_img   [`RAM_WORDS];

    // Expected responses in request order
    addr_t exp_addr_q [$];
    data_t exp_data_q [$];
    data_t exp_mask_q [$];
    tag_t  exp_tag_q  [$];
    logic  req_seen;

    // Address map: ROM 0x0000-0x00FF, RAM 0x1000-0x13FF
    function automatic region_t decode_region(input addr_t a);
        if (a <= 16'h00FF) begin
            return REGION_ROM;
        end
        if (a >= 16'h1000 && a <= 16'h13FF) begin
            return REGION_RAM;
        end
        return REGION_UNMAPPED;
    endfunction

    function automatic data_t lane_mask(input strb_t lanes);
        data_t m;
        m = '0;
        for (int l = 0; l < `MEM_LANES; l++) begin
            if (lanes[l]) begin
                m[l*8 +: 8] = 8'hFF;
            end
        end
        return m;
    endfunction

    // Runs on the rising edge, inputs are stable there
    task automatic capture_request();
        int    idx;
        data_t exp_data;
        data_t exp_mask;
        tag_t  exp_tag;
        if (rst_i === 1'b1) begin
            for (int w = 0; w < `RAM_WORDS; w++) begin
                ram_known[w] = '0;
                tag_img[w]   = '0;
            end
            exp_addr_q.delete();
            exp_data_q.delete();
            exp_mask_q.delete();
            exp_tag_q.delete();
            req_seen = 1'b0;
        end else begin
            req_seen = (req_i === 1'b1);
            if (req_seen) begin
                exp_mask = '1;
                exp_tag  = '0;
                case (decode_region(addr_i))
                    REGION_ROM: begin
                        exp_data = {`ROM_SIGNATURE, 16'(addr_i[7:2])};
                    end
                    REGION_RAM: begin
                        idx      = int'((addr_i - 16'h1000) >> 2);
                        // Old word first, then this cycle's writes
                        exp_data = ram_img[idx];
                        exp_mask = lane_mask(ram_known[idx]);
                        exp_tag  = tag_img[idx];
                        for (int l = 0; l < `MEM_LANES; l++) begin
                            if (be_i[l] && we_i) begin
                                ram_img[idx][l*8 +: 8] = wdata_i[l*8 +: 8];
                                ram_known[idx][l]      = 1'b1;
                            end
                            if (be_i[l] && we_tag_i) begin
                                tag_img[idx][l] = wdata_tag_i;
                            end
                        end
                    end
                    default: begin
                        exp_data = '0;
                    end
                endcase
                exp_addr_q.push_back(addr_i);
                exp_data_q.push_back(exp_data);
                exp_mask_q.push_back(exp_mask);
                exp_tag_q.push_back(exp_tag);
            end
        end
        pending_o = exp_data_q.size();
    endtask

    // Runs on the falling edge, outputs have settled by then
    task automatic check_response();
        addr_t a;
        data_t d;
        data_t m;
        tag_t  t;
        if (rvalid_i === 1'b1 && !req_seen) begin
            $display("Unexpected response at time %0t without a request", $time);
            err_count_o++;
        end else if (req_seen && exp_data_q.size() > 0) begin
            a = exp_addr_q.pop_front();
            d = exp_data_q.pop_front();
            m = exp_mask_q.pop_front();
            t = exp_tag_q.pop_front();
            check_count_o++;
            if (rvalid_i !== 1'b1) begin
                $display("Response for address %h missing at time %0t", a, $time);
                err_count_o++;
            end else if (((rdata_i ^ d) & m) !== '0) begin
                $display("ERR %0t: read of %h gave data %h, expected %h under mask %h",
                         $time, a, rdata_i, d, m);
                err_count_o++;
            end else if (rdata_tag_i !== t) begin
                $display("ERR %0t: read of %h gave tags %b, expected %b",
                         $time, a, rdata_tag_i, t);
                err_count_o++;
            end
        end
        pending_o = exp_data_q.size();
    endtask

    initial begin
        err_count_o   = 0;
        check_count_o = 0;
        pending_o     = 0;
        req_seen      = 1'b0;
        forever begin
            @(posedge lsdom_seq);
            capture_request();
            @(negedge lsdom_seq);
            check_response();
        end
    end

endmodule

//--- bench/mem_subsystem_sva.sv
`include "mem_defs.svh"

module mem_subsystem_sva
    import mem_pkg::*;
(
    input logic  lsdom_seq,
    input logic  rst_i,
    input logic  req_i,
    input addr_t addr_i,
    input logic  rvalid_o,
    input tag_t  rdata_tag_o
);

    localparam addr_t ROM_END = addr_t'(`ROM_WORDS * `MEM_LANES);

    // One response exactly one cycle after each request
    a_rvalid_after_req: assert property (
        @(posedge lsdom_seq) disable iff (rst_i) req_i |=> rvalid_o
    ) else $error("rvalid_o missing one cycle after a request");

    a_no_rvalid_without_req: assert property (
        @(posedge lsdom_seq) disable iff (rst_i) !req_i |=> !rvalid_o
    ) else $error("rvalid_o raised without a request");

    a_rvalid_low_after_reset: assert property (
        @(posedge lsdom_seq) $fell(rst_i) |-> !rvalid_o
    ) else $error("rvalid_o high in the first cycle after reset");

    // ROM words never carry taint
    a_rom_tags_zero: assert property (
        @(posedge lsdom_seq) disable iff (rst_i)
            (req_i && addr_i < ROM_END) |=> (rdata_tag_o == '0)
    ) else $error("nonzero tags on a ROM response");

endmodule

bind mem_subsystem mem_subsystem_sva i_mem_subsystem_sva (
    .lsdom_seq   (lsdom_seq),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .rvalid_o    (rvalid_o),
    .rdata_tag_o (rdata_tag_o)
);

//--- bench/mem_subsystem_tb.sv
`include "mem_defs.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int RESP_TIMEOUT = 50;

    logic  lsdom_seq;
    logic  rst_i;
    logic  req_i;
    addr_t addr_i;
    logic  we_i;
    strb_t be_i;
    data_t wdata_i;
    logic  we_tag_i;
    logic  wdata_tag_i;
    logic  rvalid_o;
    data_t rdata_o;
    tag_t  rdata_tag_o;

    int err_count;
    int check_count;
    int pending;
    int err_base;
    int req_total;
    int tests_done;
    bit timed_out;

    mem_subsystem uut (
        .lsdom_seq   (lsdom_seq),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .be_i        (be_i),
        .wdata_i     (wdata_i),
        .we_tag_i    (we_tag_i),
        .wdata_tag_i (wdata_tag_i),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .rdata_tag_o (rdata_tag_o)
    );

    mem_checker i_mem_checker (
        .lsdom_seq     (lsdom_seq),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .we_i          (we_i),
        .be_i          (be_i),
        .wdata_i       (wdata_i),
        .we_tag_i      (we_tag_i),
        .wdata_tag_i   (wdata_tag_i),
        .rvalid_i      (rvalid_o),
        .rdata_i       (rdata_o),
        .rdata_tag_i   (rdata_tag_o),
        .err_count_o   (err_count),
        .check_count_o (check_count),
        .pending_o     (pending)
    );

    initial begin
        lsdom_seq = 1'b0;
        forever #20 lsdom_seq = ~lsdom_seq;
    end

    task automatic send(input addr_t addr, input logic we, input strb_t be,
                        input data_t wdata, input logic we_tag, input logic wtag);
        @(negedge lsdom_seq);
        req_i       = 1'b1;
        addr_i      = addr;
        we_i        = we;
        be_i        = be;
        wdata_i     = wdata;
        we_tag_i    = we_tag;
        wdata_tag_i = wtag;
        req_total++;
    endtask

    task automatic go_idle();
        @(negedge lsdom_seq);
        req_i       = 1'b0;
        addr_i      = '0;
        we_i        = 1'b0;
        be_i        = '0;
        wdata_i     = '0;
        we_tag_i    = 1'b0;
        wdata_tag_i = 1'b0;
    endtask

    task automatic read_word(input addr_t addr);
        send(addr, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    // Random addresses with random low two bits
    function automatic addr_t rom_addr();
        return addr_t'(($urandom % `ROM_WORDS) * 4 + $urandom % 4);
    endfunction

    function automatic addr_t ram_addr(input int words);
        return addr_t'(32'h1000 + ($urandom % words) * 4 + $urandom % 4);
    endfunction

    function automatic addr_t unmapped_addr();
        if ($urandom % 2 == 0) begin
            return addr_t'(32'h0100 + $urandom % 32'h0F00);
        end
        return addr_t'(32'h1400 + $urandom % 32'hEC00);
    endfunction

    task automatic send_random(input int region);
        addr_t a;
        case (region)
            0:       a = rom_addr();
            1:       a = ram_addr(32);
            default: a = unmapped_addr();
        endcase
        send(a, 1'($urandom), strb_t'($urandom), data_t'($urandom), 1'($urandom), 1'($urandom));
    endtask

    // Wait until the response port goes quiet, then report the test
    task automatic finish_test(input string name);
        int cycles;
        go_idle();
        cycles = 0;
        do begin
            @(negedge lsdom_seq);
            cycles++;
        end while ((pending != 0 || rvalid_o !== 1'b0) && cycles < RESP_TIMEOUT);
        if (pending != 0 || rvalid_o !== 1'b0) begin
            $display("Timeout in test %s, rvalid_o still active after %0d cycles",
                     name, cycles);
            timed_out = 1'b1;
        end
        $display("Test %s finished with %0d errors", name, err_count - err_base);
        err_base = err_count;
        tests_done++;
    endtask

    task automatic reset_state_reads();
        repeat (3) go_idle();
        for (int i = 0; i < 8; i++) begin
            read_word(ram_addr(`RAM_WORDS));
        end
        finish_test("reset_state");
    endtask

    task automatic rom_reads_and_writes();
        addr_t hits [8];
        for (int i = 0; i < 16; i++) begin
            read_word(rom_addr());
        end
        for (int i = 0; i < 8; i++) begin
            hits[i] = rom_addr();
            send(hits[i], 1'b1, strb_t'($urandom), data_t'($urandom), 1'b1, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(hits[i]);
        end
        finish_test("rom");
    endtask

    task automatic ram_byte_writes();
        addr_t a;
        for (int i = 0; i < 8; i++) begin
            send(addr_t'(32'h1000 + i * 4), 1'b1, 4'hF, data_t'($urandom), 1'b0, 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            a = ram_addr(16);
            send(a, 1'b1, strb_t'($urandom), data_t'($urandom), 1'b0, 1'b0);
            read_word(a);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(addr_t'(32'h1000 + i * 4));
        end
        finish_test("ram_data");
    endtask

    task automatic tag_writes();
        int kind;
        for (int i = 0; i < 40; i++) begin
            kind = int'($urandom % 3);
            case (kind)
                0: send(ram_addr(8), 1'b0, strb_t'($urandom), '0, 1'b1, 1'($urandom));
                // Data-only write whose tag bit input is ignored
                1: send(ram_addr(8), 1'b1, strb_t'($urandom), data_t'($urandom), 1'b0, 1'b1);
                default: read_word(ram_addr(8));
            endcase
        end
        for (int i = 0; i < 8; i++) begin
            read_word(addr_t'(32'h1000 + i * 4));
        end
        finish_test("tags");
    endtask

    task automatic unmapped_reads();
        for (int i = 0; i < 16; i++) begin
            send_random(2);
        end
        finish_test("unmapped");
    endtask

    task automatic back_to_back_run();
        for (int i = 0; i < 400; i++) begin
            send_random(int'($urandom % 3));
        end
        finish_test("back_to_back");
    endtask

    initial begin
        rst_i       = 1'b1;
        req_i       = 1'b0;
        addr_i      = '0;
        we_i        = 1'b0;
        be_i        = '0;
        wdata_i     = '0;
        we_tag_i    = 1'b0;
        wdata_tag_i = 1'b0;
        err_base    = 0;
        req_total   = 0;
        tests_done  = 0;
        timed_out   = 1'b0;
        void'($urandom(32'h5174));

        repeat (4) @(posedge lsdom_seq);
        @(negedge lsdom_seq);
        rst_i = 1'b0;

        reset_state_reads();
        if (!timed_out) rom_reads_and_writes();
        if (!timed_out) ram_byte_writes();
        if (!timed_out) tag_writes();
        if (!timed_out) unmapped_reads();
        if (!timed_out) back_to_back_run();

        $display("Summary: %0d tests, %0d requests, %0d responses checked, %0d errors",
                 tests_done, req_total, check_count, err_count);
        if (!timed_out && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- logic/boot_rom.sv
`include "mem_defs.svh"

module boot_rom
    import mem_pkg::*;
(
    input  logic  lsdom_seq,
    input  logic  req_i,
    input  addr_t word_idx_i,
    output data_t rdata_o
);

    localparam int ROM_IDX_W = $clog2(`ROM_WORDS);
    localparam int HALF_W    = `MEM_DATA_WIDTH / 2;

    data_t                rom_table [`ROM_WORDS];
    logic [ROM_IDX_W-1:0] rom_idx;

    // Word i holds the signature on top and its own index below
    for (genvar i = 0; i < `ROM_WORDS; i++) begin : gen_rom_words
        assign rom_table[i] = {`ROM_SIGNATURE, HALF_W'(i)};
    end

    // The mux only strobes us for in-range words
    assign rom_idx = word_idx_i[ROM_IDX_W-1:0];

    // Synchronous read, result valid the cycle after the strobe
    always_ff @(posedge lsdom_seq) begin
        if (req_i) begin
            rdata_o <= rom_table[rom_idx];
        end
    end

endmodule

//--- logic/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Data word and byte address widths
`define MEM_DATA_WIDTH 32
`define MEM_ADDR_WIDTH 16

// Byte lanes per word, one taint tag bit per lane
`define MEM_LANES 4

// Boot ROM covers bytes 0x0000 to 0x00FF
`define ROM_WORDS 64

// Upper half of every ROM word
`define ROM_SIGNATURE 16'hB007

// Tagged RAM covers bytes 0x1000 to 0x13FF
`define RAM_BASE 16'h1000
`define RAM_WORDS 256

`endif

//--- logic/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // Byte address on the request port
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

    // One data word
    typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

    // Byte enables, bit n is lane n
    typedef logic [`MEM_LANES-1:0] strb_t;

    // Taint tags of one word, bit n is lane n
    typedef logic [`MEM_LANES-1:0] tag_t;

    // Decoded target of a request
    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_UNMAPPED
    } region_t;

endpackage

//--- logic/mem_region_mux.sv
`include "mem_defs.svh"

module mem_region_mux
    import mem_pkg::*;
(
    input  logic  lsdom_seq,
    input  logic  rst_i,
    input  logic  req_i,
    input  addr_t addr_i,

    output logic  rom_req_o,
    output logic  ram_req_o,
    output addr_t word_idx_o,

    input  data_t rom_rdata_i,
    input  data_t ram_rdata_i,
    input  tag_t  ram_rdata_tag_i,

    output logic  rvalid_o,
    output data_t rdata_o,
    output tag_t  rdata_tag_o
);

    // Byte offset bits dropped when forming a word index
    localparam int OFFS_W = $clog2(`MEM_LANES);

    // Region limits, exclusive upper bounds
    localparam addr_t ROM_LIMIT = addr_t'(`ROM_WORDS * `MEM_LANES);
    localparam addr_t RAM_START = `RAM_BASE;
    localparam addr_t RAM_LIMIT = addr_t'(`RAM_BASE + `RAM_WORDS * `MEM_LANES);

    region_t region_d;
    region_t region_q;
    logic    rvalid_q;
    addr_t   ram_offs;

    assign ram_offs = addr_i - RAM_START;

    // Address decode
    always_comb begin
        if (addr_i < ROM_LIMIT) begin
            region_d = REGION_ROM;
        end else if (addr_i >= RAM_START && addr_i < RAM_LIMIT) begin
            region_d = REGION_RAM;
        end else begin
            region_d = REGION_UNMAPPED;
        end
    end

    // Word index relative to the selected region's base
    always_comb begin
        case (region_d)
            REGION_ROM: word_idx_o = addr_i >> OFFS_W;
            REGION_RAM: word_idx_o = ram_offs >> OFFS_W;
            default:    word_idx_o = '0;
        endcase
    end

    // Only the chosen region sees the strobe
    assign rom_req_o = req_i && (region_d == REGION_ROM);
    assign ram_req_o = req_i && (region_d == REGION_RAM);

    // Response tracking, one cycle behind the request
    always_ff @(posedge lsdom_seq) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
            region_q <= REGION_UNMAPPED;
        end else begin
            rvalid_q <= req_i;
            if (req_i) begin
                region_q <= region_d;
            end
        end
    end

    assign rvalid_o = rvalid_q;

    // Merge the region results
    // ROM words never carry taint
    always_comb begin
        case (region_q)
            REGION_ROM: begin
                rdata_o     = rom_rdata_i;
                rdata_tag_o = '0;
            end
            REGION_RAM: begin
                rdata_o     = ram_rdata_i;
                rdata_tag_o = ram_rdata_tag_i;
            end
            default: begin
                rdata_o     = '0;
                rdata_tag_o = '0;
            end
        endcase
    end

endmodule

//--- logic/mem_subsystem.sv
module mem_subsystem
    import mem_pkg::*;
(
    input  logic  lsdom_seq,
    input  logic  rst_i,

    // Direct request port
    input  logic  req_i,
    input  addr_t addr_i,
    input  logic  we_i,
    input  strb_t be_i,
    input  data_t wdata_i,
    input  logic  we_tag_i,
    input  logic  wdata_tag_i,

    // Read response
    output logic  rvalid_o,
    output data_t rdata_o,
    output tag_t  rdata_tag_o
);

    logic  rom_req;
    logic  ram_req;
    addr_t word_idx;

    data_t rom_rdata;
    data_t ram_rdata;
    tag_t  ram_rdata_tag;

    mem_region_mux i_mem_region_mux (
        .lsdom_seq       (lsdom_seq),
        .rst_i           (rst_i),
        .req_i           (req_i),
        .addr_i          (addr_i),

        .rom_req_o       (rom_req),
        .ram_req_o       (ram_req),
        .word_idx_o      (word_idx),

        .rom_rdata_i     (rom_rdata),
        .ram_rdata_i     (ram_rdata),
        .ram_rdata_tag_i (ram_rdata_tag),

        .rvalid_o        (rvalid_o),
        .rdata_o         (rdata_o),
        .rdata_tag_o     (rdata_tag_o)
    );

    boot_rom i_boot_rom (
        .lsdom_seq  (lsdom_seq),
        .req_i      (rom_req),
        .word_idx_i (word_idx),
        .rdata_o    (rom_rdata)
    );

    // Write controls come straight from the port, the strobe gates them
    tagged_ram i_tagged_ram (
        .lsdom_seq   (lsdom_seq),
        .rst_i       (rst_i),
        .req_i       (ram_req),
        .word_idx_i  (word_idx),

        .we_i        (we_i),
        .be_i        (be_i),
        .wdata_i     (wdata_i),

        .we_tag_i    (we_tag_i),
        .wdata_tag_i (wdata_tag_i),

        .rdata_o     (ram_rdata),
        .rdata_tag_o (ram_rdata_tag)
    );

endmodule

//--- logic/tagged_ram.sv
`include "mem_defs.svh"

module tagged_ram
    import mem_pkg::*;
(
    input  logic  lsdom_seq,
    input  logic  rst_i,
    input  logic  req_i,
    input  addr_t word_idx_i,

    input  logic  we_i,
    input  strb_t be_i,
    input  data_t wdata_i,

    input  logic  we_tag_i,
    input  logic  wdata_tag_i,

    output data_t rdata_o,
    output tag_t  rdata_tag_o
);

    localparam int RAM_IDX_W = $clog2(`RAM_WORDS);
    localparam int LANE_W    = `MEM_DATA_WIDTH / `MEM_LANES;

    data_t                data_mem [`RAM_WORDS];
    tag_t                 tag_mem  [`RAM_WORDS];
    logic [RAM_IDX_W-1:0] ram_idx;

    assign ram_idx = word_idx_i[RAM_IDX_W-1:0];

    // Data array
    // Read returns the word as it was before this cycle's write
    always_ff @(posedge lsdom_seq) begin
        if (req_i) begin
            rdata_o <= data_mem[ram_idx];
            if (we_i) begin
                for (int l = 0; l < `MEM_LANES; l++) begin
                    if (be_i[l]) begin
                        data_mem[ram_idx][l*LANE_W +: LANE_W] <= wdata_i[l*LANE_W +: LANE_W];
                    end
                end
            end
        end
    end

    // Tag array
    // One tag bit per lane, all lanes start untainted
    always_ff @(posedge lsdom_seq) begin
        if (rst_i) begin
            for (int w = 0; w < `RAM_WORDS; w++) begin
                tag_mem[w] <= '0;
            end
            rdata_tag_o <= '0;
        end else if (req_i) begin
            rdata_tag_o <= tag_mem[ram_idx];
            if (we_tag_i) begin
                for (int l = 0; l < `MEM_LANES; l++) begin
                    // The single tag bit fans out to every enabled lane
                    if (be_i[l]) begin
                        tag_mem[ram_idx][l] <= wdata_tag_i;
                    end
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module mem_subsystem_tb \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmem_subsystem_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sources.f
+incdir+logic
logic/mem_pkg.sv
logic/boot_rom.sv
logic/tagged_ram.sv
logic/mem_region_mux.sv
logic/mem_subsystem.sv
bench/mem_checker.sv
bench/mem_subsystem_sva.sv
bench/mem_subsystem_tb.sv
